//--- common/axi_pkg.sv
`default_nettype none

package axi_pkg;

  localparam int axi_addr_bits = 32;
  localparam int axi_data_bits = 32;
  localparam int axi_id_bits   = 4;
  localparam int axi_ids_bits  = 8;   // Master index above master ID
  localparam int axi_midx_bits = axi_ids_bits - axi_id_bits;
  localparam int axi_len_bits  = 4;

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;
  localparam logic [1:0] resp_decerr = 2'b11;

  // Master side read address
  typedef struct packed {
    logic [axi_id_bits-1:0]   arid;
    logic [axi_addr_bits-1:0] araddr;
    logic [axi_len_bits-1:0]  arlen;
    logic                     arvalid;
  } axi_ar_m_t;

  // Slave side read address, widened ID
  typedef struct packed {
    logic [axi_ids_bits-1:0]  arid;
    logic [axi_addr_bits-1:0] araddr;
    logic [axi_len_bits-1:0]  arlen;
    logic                     arvalid;
  } axi_ar_s_t;

  typedef struct packed {
    logic [axi_id_bits-1:0]   rid;
    logic [axi_data_bits-1:0] rdata;
    logic [1:0]               rresp;
    logic                     rlast;
    logic                     rvalid;
  } axi_r_m_t;

  typedef struct packed {
    logic [axi_ids_bits-1:0]  rid;
    logic [axi_data_bits-1:0] rdata;
    logic [1:0]               rresp;
    logic                     rlast;
    logic                     rvalid;
  } axi_r_s_t;

  typedef struct packed {
    logic [axi_midx_bits-1:0] midx;  // Issuing master
    logic [axi_id_bits-1:0]   mid;   // ID as the master sent it
  } axi_ids_fields_t;

  // Slave side ID, raw or split
  typedef union packed {
    logic [axi_ids_bits-1:0] raw;
    axi_ids_fields_t         fld;
  } axi_ids_u;

endpackage

`default_nettype wire

//--- common/xbar_map_pkg.sv
`default_nettype none

package xbar_map_pkg;
  import axi_pkg::*;

  localparam int num_masters = 2;
  localparam int num_slaves  = 3;

  // Region is the top two address bits
  localparam int         region_bits = 2;
  localparam logic [1:0] region_s0   = 2'd0;
  localparam logic [1:0] region_s1   = 2'd1;
  localparam logic [1:0] region_s2   = 2'd2;
  localparam logic [1:0] region_rsvd = 2'd3;

  typedef enum logic [1:0] {S0, S1, S2} slave_sel_t;
  typedef enum logic [1:0] {LOCK_NO, LOCK_S0, LOCK_S1, LOCK_S2} data_arb_lock_t;
  typedef enum logic [1:0] {LOCK_NONE, LOCK_M0, LOCK_M1} addr_arb_lock_t;
  typedef enum logic [1:0] {MASTER_0, MASTER_1, MASTER_2, MASTER_U} master_sel_t;

  function automatic master_sel_t data_decoder(input logic [axi_ids_bits-1:0] id);
    axi_ids_u ids;
    ids.raw = id;
    case (ids.fld.midx)
      axi_midx_bits'(0): return MASTER_0;
      axi_midx_bits'(1): return MASTER_1;
      axi_midx_bits'(2): return MASTER_2;
      default:           return MASTER_U;
    endcase
  endfunction

  function automatic slave_sel_t addr_decoder(input logic [axi_addr_bits-1:0] addr);
    logic [region_bits-1:0] region;
    region = addr[axi_addr_bits-1 -: region_bits];
    case (region)
      region_s0:   return S0;
      region_s1:   return S1;
      region_s2:   return S2;
      region_rsvd: return S0;  // Never issued
    endcase
  endfunction

endpackage

`default_nettype wire

//--- xbar/ar_router.sv
`default_nettype none

module ar_router
  import axi_pkg::*, xbar_map_pkg::*;
(
  input  logic      clk,
  input  logic      rstn,
  // Masters
  input  axi_ar_m_t ar_m0,
  output logic      arready_m0,
  input  axi_ar_m_t ar_m1,
  output logic      arready_m1,
  // Slaves
  output axi_ar_s_t ar_s0,
  input  logic      arready_s0,
  output axi_ar_s_t ar_s1,
  input  logic      arready_s1,
  output axi_ar_s_t ar_s2,
  input  logic      arready_s2
);

  addr_arb_lock_t lock, lock_next;

  axi_ar_s_t ar_w [num_masters];
  axi_ar_s_t req;
  axi_ar_s_t req_r;   // Copy held while the slave stalls
  logic      grant_m1;
  logic      sready;
  logic      accept;

  // Master index goes into the upper ID field
  function automatic axi_ar_s_t widen(input axi_ar_m_t ar,
                                     input logic [axi_midx_bits-1:0] midx);
    axi_ids_u ids;
    ids.fld.midx = midx;
    ids.fld.mid  = ar.arid;
    return '{arid: ids.raw, araddr: ar.araddr, arlen: ar.arlen, arvalid: ar.arvalid};
  endfunction

  assign ar_w[0] = widen(ar_m0, axi_midx_bits'(0));
  assign ar_w[1] = widen(ar_m1, axi_midx_bits'(1));

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      lock <= LOCK_NONE;
    end else begin
      lock <= lock_next;
    end
  end

  // Loaded whenever a lock is entered
  always_ff @(posedge clk) begin
    if (lock_next != LOCK_NONE && lock_next != lock) begin
      req_r <= (lock_next == LOCK_M1) ? ar_w[1] : ar_w[0];
    end
  end

  // Master select
  always_comb begin
    unique case (lock)
      LOCK_M0: grant_m1 = 1'b0;
      LOCK_M1: grant_m1 = 1'b1;
      default: grant_m1 = !ar_m0.arvalid;  // M0 first when unlocked
    endcase

    if (lock == LOCK_NONE) begin
      req = grant_m1 ? ar_w[1] : ar_w[0];
    end else begin
      req = req_r;
      req.arvalid = 1'b1;
    end
  end

  // Address decode to slave
  always_comb begin
    ar_s0  = '0;
    ar_s1  = '0;
    ar_s2  = '0;
    sready = 1'b0;
    case (addr_decoder(req.araddr))
      S0: begin
        ar_s0  = req;
        sready = arready_s0;
      end
      S1: begin
        ar_s1  = req;
        sready = arready_s1;
      end
      S2: begin
        ar_s2  = req;
        sready = arready_s2;
      end
      default: ;
    endcase
  end

  assign accept     = req.arvalid & sready;
  assign arready_m0 = accept & !grant_m1;
  assign arready_m1 = accept & grant_m1;

  always_comb begin
    lock_next = lock;
    unique case (lock)
      LOCK_NONE: begin
        if (req.arvalid && !sready) begin
          lock_next = grant_m1 ? LOCK_M1 : LOCK_M0;
        end
      end
      LOCK_M0: if (sready) lock_next = ar_m1.arvalid ? LOCK_M1 : LOCK_NONE;  // Other one next
      LOCK_M1: if (sready) lock_next = ar_m0.arvalid ? LOCK_M0 : LOCK_NONE;
      default: lock_next = LOCK_NONE;
    endcase
  end

endmodule

`default_nettype wire

//--- xbar/r_router.sv
`default_nettype none

module r_router
  import axi_pkg::*, xbar_map_pkg::*;
(
  input  logic     clk,
  input  logic     rstn,
  // Slaves
  input  axi_r_s_t r_s0,
  output logic     rready_s0,
  input  axi_r_s_t r_s1,
  output logic     rready_s1,
  input  axi_r_s_t r_s2,
  output logic     rready_s2,
  // Masters
  output axi_r_m_t r_m0,
  input  logic     rready_m0,
  output axi_r_m_t r_m1,
  input  logic     rready_m1
);

  data_arb_lock_t lock, lock_next;

  logic [num_slaves-1:0] s_valid;
  axi_r_s_t              beat;     // Beat offered this cycle
  axi_r_s_t              beat_r;
  axi_r_m_t              beat_m;
  slave_sel_t            src;
  master_sel_t           dst;
  axi_ids_u              ids;
  logic                  mready;   // Ready of the addressed master

  assign s_valid = {r_s2.rvalid, r_s1.rvalid, r_s0.rvalid};

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      lock <= LOCK_NO;
    end else begin
      lock <= lock_next;
    end
  end

  // Capture the beat of the slave being locked to
  always_ff @(posedge clk) begin
    if (lock_next != LOCK_NO && lock_next != lock) begin
      case (lock_next)
        LOCK_S1: beat_r <= r_s1;
        LOCK_S2: beat_r <= r_s2;
        default: beat_r <= r_s0;
      endcase
    end
  end

  // Arbiter
  always_comb begin
    src  = S0;
    beat = '0;
    unique case (lock)
      LOCK_S0: begin
        src = S0;
        beat = beat_r;
        beat.rvalid = 1'b1;  // Held until taken
      end
      LOCK_S1: begin
        src = S1;
        beat = beat_r;
        beat.rvalid = 1'b1;
      end
      LOCK_S2: begin
        src = S2;
        beat = beat_r;
        beat.rvalid = 1'b1;
      end
      LOCK_NO: begin
        // Fixed priority, S0 highest
        if (s_valid[0]) begin
          src  = S0;
          beat = r_s0;
        end else if (s_valid[1]) begin
          src  = S1;
          beat = r_s1;
        end else if (s_valid[2]) begin
          src  = S2;
          beat = r_s2;
        end
      end
    endcase
  end

  // Decoder
  always_comb begin
    ids.raw = beat.rid;
    dst     = data_decoder(ids.raw);
    beat_m  = '{rid: ids.fld.mid, rdata: beat.rdata, rresp: beat.rresp,
                rlast: beat.rlast, rvalid: beat.rvalid};
    r_m0    = '0;
    r_m1    = '0;
    mready  = 1'b0;
    case (dst)
      MASTER_0: begin
        r_m0   = beat_m;
        mready = rready_m0;
      end
      MASTER_1: begin
        r_m1   = beat_m;
        mready = rready_m1;
      end
      default: ;  // No such master
    endcase
  end

  assign rready_s0 = beat.rvalid & mready & (src == S0);
  assign rready_s1 = beat.rvalid & mready & (src == S1);
  assign rready_s2 = beat.rvalid & mready & (src == S2);

  always_comb begin
    lock_next = lock;
    unique case (lock)
      LOCK_NO: begin
        if (beat.rvalid && !mready) begin
          case (src)
            S1:      lock_next = LOCK_S1;
            S2:      lock_next = LOCK_S2;
            default: lock_next = LOCK_S0;
          endcase
        end
      end
      // Rotate, starting after the slave just served
      LOCK_S0: if (mready) lock_next = s_valid[1] ? LOCK_S1 : s_valid[2] ? LOCK_S2 : LOCK_NO;
      LOCK_S1: if (mready) lock_next = s_valid[2] ? LOCK_S2 : s_valid[0] ? LOCK_S0 : LOCK_NO;
      LOCK_S2: if (mready) lock_next = s_valid[0] ? LOCK_S0 : s_valid[1] ? LOCK_S1 : LOCK_NO;
    endcase
  end

endmodule

`default_nettype wire

//--- xbar/read_xbar.sv
`default_nettype none

module read_xbar
  import axi_pkg::*;
(
  input  logic      clk,
  input  logic      rstn,
  // Master 0
  input  axi_ar_m_t ar_m0,
  output logic      arready_m0,
  output axi_r_m_t  r_m0,
  input  logic      rready_m0,
  // Master 1
  input  axi_ar_m_t ar_m1,
  output logic      arready_m1,
  output axi_r_m_t  r_m1,
  input  logic      rready_m1,
  // Slave 0
  output axi_ar_s_t ar_s0,
  input  logic      arready_s0,
  input  axi_r_s_t  r_s0,
  output logic      rready_s0,
  // Slave 1
  output axi_ar_s_t ar_s1,
  input  logic      arready_s1,
  input  axi_r_s_t  r_s1,
  output logic      rready_s1,
  // Slave 2
  output axi_ar_s_t ar_s2,
  input  logic      arready_s2,
  input  axi_r_s_t  r_s2,
  output logic      rready_s2
);

  ar_router u_ar_router (
    .clk,
    .rstn,
    .ar_m0,
    .arready_m0,
    .ar_m1,
    .arready_m1,
    .ar_s0,
    .arready_s0,
    .ar_s1,
    .arready_s1,
    .ar_s2,
    .arready_s2
  );

  r_router u_r_router (
    .clk,
    .rstn,
    .r_s0,
    .rready_s0,
    .r_s1,
    .rready_s1,
    .r_s2,
    .rready_s2,
    .r_m0,
    .rready_m0,
    .r_m1,
    .rready_m1
  );

endmodule

`default_nettype wire

//--- test/axi_slave_model.sv
`default_nettype none

module axi_slave_model
  import axi_pkg::*;
(
  input  logic       clk,
  input  logic       rstn,
  input  logic [3:0] idx,      // Slave number shown in rdata
  input  logic [7:0] latency,  // Cycles before the first beat
  input  axi_ar_s_t  ar,
  output logic       arready,
  output axi_r_s_t   r,
  input  logic       rready
);

  axi_ar_s_t  cur;
  logic       busy;
  logic [7:0] wait_cnt;
  logic [3:0] k;

  function automatic axi_r_s_t make_beat(input logic [3:0] n);
    axi_r_s_t b;
    b.rid    = cur.arid;
    b.rdata  = {idx, cur.araddr[27:0] + {22'd0, n, 2'b00}};
    b.rresp  = (cur.araddr[15:12] == 4'hf) ? resp_slverr : resp_okay;
    b.rlast  = (n == cur.arlen);
    b.rvalid = 1'b1;
    return b;
  endfunction

  assign arready = !busy;  // One read at a time

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      busy     <= 1'b0;
      cur      <= '0;
      wait_cnt <= '0;
      k        <= '0;
      r        <= '0;
    end else if (!busy) begin
      if (ar.arvalid) begin
        busy     <= 1'b1;
        cur      <= ar;
        wait_cnt <= latency;
        k        <= '0;
      end
    end else if (r.rvalid) begin
      if (rready && r.rlast) begin
        busy <= 1'b0;
        r    <= '0;
      end else if (rready) begin
        k <= k + 1'b1;
        r <= make_beat(k + 1'b1);  // Next beat right away
      end
    end else if (wait_cnt > 8'd1) begin
      wait_cnt <= wait_cnt - 1'b1;
    end else begin
      r <= make_beat(k);
    end
  end

endmodule

`default_nettype wire

//--- test/read_xbar_props.sv
`default_nettype none

module read_xbar_props
  import axi_pkg::*, xbar_map_pkg::*;
(
  input logic        clk,
  input logic        rstn,
  input logic        addr_chan,   // High on the AR channel, low on R
  input logic        vld,
  input logic        rdy,
  input logic [63:0] payload,     // Whole channel, zero padded
  input logic [7:0]  route_id,    // Slave side ID
  input logic [31:0] route_addr
);

  // Upper ID field must name one of the two masters
  a_known_master: assert property (@(posedge clk) disable iff (!rstn)
    vld && !addr_chan |->
      (data_decoder(route_id) != MASTER_2 && data_decoder(route_id) != MASTER_U))
    else $error("Transfer carries ID %h of no existing master", route_id);

  a_hold_until_taken: assert property (@(posedge clk) disable iff (!rstn)
    vld && !rdy |=> vld && $stable(payload))
    else $error("Stalled transfer changed before it was accepted");

  // Region 3 is reserved
  a_no_region3: assert property (@(posedge clk) disable iff (!rstn)
    vld && addr_chan |-> route_addr[31:30] != 2'd3)
    else $error("Address %h in the reserved region was issued", route_addr);

endmodule

`default_nettype wire

//--- test/read_xbar_tb.sv
`default_nettype none

module read_xbar_tb
  import axi_pkg::*;
();

  localparam int max_cycles = 4000;  // About four times the test length

  logic      clk;
  logic      rstn;
  axi_ar_m_t ar_m0, ar_m1;
  logic      arready_m0, arready_m1;
  axi_r_m_t  r_m0, r_m1;
  logic      rready_m0, rready_m1;
  axi_ar_s_t ar_s0, ar_s1, ar_s2;
  logic      arready_s0, arready_s1, arready_s2;
  axi_r_s_t  r_s0, r_s1, r_s2;
  logic      rready_s0, rready_s1, rready_s2;

  axi_r_m_t got0[$];  // Beats accepted by M0, in order
  axi_r_m_t got1[$];
  axi_r_m_t last0, last1;
  logic     stall0 = 1'b0;
  logic     stall1 = 1'b0;
  int       rd0 = 0;
  int       rd1 = 0;
  int       cycles = 0;
  int       checks = 0;
  int       errors = 0;
  int       hold_errors = 0;

  read_xbar uut (.*);

  axi_slave_model s0_model (.clk, .rstn, .idx(4'd0), .latency(8'd1), .ar(ar_s0),
                            .arready(arready_s0), .r(r_s0), .rready(rready_s0));
  axi_slave_model s1_model (.clk, .rstn, .idx(4'd1), .latency(8'd3), .ar(ar_s1),
                            .arready(arready_s1), .r(r_s1), .rready(rready_s1));
  axi_slave_model s2_model (.clk, .rstn, .idx(4'd2), .latency(8'd5), .ar(ar_s2),
                            .arready(arready_s2), .r(r_s2), .rready(rready_s2));

  // R channel carries no address
  bind r_router read_xbar_props r_props (.clk(clk), .rstn(rstn), .addr_chan(1'b0),
    .vld(beat.rvalid), .rdy(mready), .payload({20'd0, beat}), .route_id(beat.rid),
    .route_addr(32'd0));
  bind ar_router read_xbar_props ar_props (.clk(clk), .rstn(rstn), .addr_chan(1'b1),
    .vld(req.arvalid), .rdy(sready), .payload({19'd0, req}), .route_id(req.arid),
    .route_addr(req.araddr));

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("Timeout after %0d cycles, a test never finished", max_cycles);
      $display("Checks failed");
      $finish;
    end
  end

  // Beat monitor, a stalled beat must come back unchanged
  always @(posedge clk) begin
    if (rstn) begin
      if (stall0 && r_m0 != last0) begin
        hold_errors++;
        $display("M0 beat changed or rvalid dropped before it was accepted");
      end
      if (stall1 && r_m1 != last1) begin
        hold_errors++;
        $display("M1 beat changed or rvalid dropped before it was accepted");
      end
      if (r_m0.rvalid && rready_m0) got0.push_back(r_m0);
      if (r_m1.rvalid && rready_m1) got1.push_back(r_m1);
      stall0 = r_m0.rvalid && !rready_m0;
      stall1 = r_m1.rvalid && !rready_m1;
      last0  = r_m0;
      last1  = r_m1;
    end
  end

  task automatic check_equal(input string test, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %h, got %h", test, what, exp, act);
    end
  endtask

  // Slave n is region n, its number sits in the top nibble
  function automatic logic [31:0] expect_data(input logic [31:0] addr, input int k);
    return {2'b00, addr[31:30], addr[27:0] + 28'(4 * k)};
  endfunction

  task automatic check_beat(input string test, input axi_r_m_t b, input logic [3:0] id,
                            input logic [31:0] addr, input int k, input int len);
    logic [31:0] resp;
    resp = (addr[15:12] == 4'hf) ? 32'(resp_slverr) : 32'(resp_okay);
    check_equal(test, "rid", 32'(id), 32'(b.rid));
    check_equal(test, "rdata", expect_data(addr, k), b.rdata);
    check_equal(test, "rresp", resp, 32'(b.rresp));
    check_equal(test, "rlast", 32'(k == len), 32'(b.rlast));
  endtask

  task automatic issue_read(input int m, input logic [3:0] id, input logic [31:0] addr,
                            input logic [3:0] len);
    axi_ar_m_t a;
    logic      done;
    a = '{arid: id, araddr: addr, arlen: len, arvalid: 1'b1};
    done = 1'b0;
    @(negedge clk);
    if (m == 0) ar_m0 = a;
    else ar_m1 = a;
    while (!done) begin
      @(posedge clk);
      done = (m == 0) ? arready_m0 : arready_m1;
    end
    @(negedge clk);
    if (m == 0) ar_m0 = '0;
    else ar_m1 = '0;
  endtask

  task automatic wait_beats(input int m, input int n);
    while ((m == 0) ? (got0.size() < rd0 + n) : (got1.size() < rd1 + n)) @(negedge clk);
  endtask

  function automatic axi_r_m_t take_beat(input int m);
    axi_r_m_t b;
    if (m == 0) begin
      b = got0[rd0];
      rd0 = rd0 + 1;
    end else begin
      b = got1[rd1];
      rd1 = rd1 + 1;
    end
    return b;
  endfunction

  task automatic check_no_extra_beats(input string test);
    repeat (10) @(negedge clk);
    check_equal(test, "extra M0 beats", 0, 32'(got0.size() - rd0));
    check_equal(test, "extra M1 beats", 0, 32'(got1.size() - rd1));
  endtask

  task automatic test_reset_state();
    check_equal("reset", "arvalid to slaves", 0,
                32'({ar_s2.arvalid, ar_s1.arvalid, ar_s0.arvalid}));
    check_equal("reset", "rvalid to masters", 0, 32'({r_m1.rvalid, r_m0.rvalid}));
    check_equal("reset", "arready to masters", 0, 32'({arready_m1, arready_m0}));
    check_equal("reset", "rready to slaves", 0, 32'({rready_s2, rready_s1, rready_s0}));
  endtask

  task automatic test_single();
    logic [31:0] addr;
    logic [3:0]  id;
    for (int m = 0; m < 2; m++) begin
      for (int s = 0; s < 3; s++) begin
        addr = {2'(s), 30'h0000_0100} + 32'(m * 16);
        id   = 4'(1 + 4 * m + s);
        issue_read(m, id, addr, 4'd0);
        wait_beats(m, 1);
        check_beat("single", take_beat(m), id, addr, 0, 0);
      end
    end
    check_no_extra_beats("single");
  endtask

  task automatic test_contention();
    fork
      issue_read(0, 4'h1, 32'h4000_0200, 4'd0);
      issue_read(1, 4'h2, 32'h4000_0300, 4'd0);
    join
    while (got0.size() == rd0 && got1.size() == rd1) @(negedge clk);
    check_equal("contention", "M0 beats first", 1, 32'(got0.size() - rd0));
    check_equal("contention", "M1 beats first", 0, 32'(got1.size() - rd1));
    wait_beats(0, 1);
    wait_beats(1, 1);
    check_beat("contention", take_beat(0), 4'h1, 32'h4000_0200, 0, 0);
    check_beat("contention", take_beat(1), 4'h2, 32'h4000_0300, 0, 0);
  endtask

  task automatic test_burst();
    issue_read(1, 4'h7, 32'h4000_1000, 4'd3);
    wait_beats(1, 4);
    for (int k = 0; k < 4; k++) check_beat("burst", take_beat(1), 4'h7, 32'h4000_1000, k, 3);
    check_no_extra_beats("burst");
  endtask

  task automatic test_backpressure();
    fork
      issue_read(0, 4'h9, 32'h8000_2000, 4'd7);
      while (got0.size() < rd0 + 8) begin
        @(negedge clk);
        rready_m0 = ($urandom() % 2) != 0;
      end
    join
    rready_m0 = 1'b1;
    for (int k = 0; k < 8; k++) begin
      check_beat("backpressure", take_beat(0), 4'h9, 32'h8000_2000, k, 7);
    end
    check_no_extra_beats("backpressure");
  endtask

  task automatic test_crossing();
    axi_r_m_t b;
    int       k4;
    int       k5;
    k4 = 0;
    k5 = 0;
    fork
      issue_read(0, 4'h3, 32'h0000_3000, 4'd3);
      begin
        issue_read(1, 4'h4, 32'h4000_3000, 4'd3);
        issue_read(1, 4'h5, 32'h8000_3000, 4'd3);
      end
    join
    wait_beats(0, 4);
    wait_beats(1, 8);
    for (int k = 0; k < 4; k++) check_beat("crossing", take_beat(0), 4'h3, 32'h0000_3000, k, 3);
    while (got1.size() > rd1) begin
      b = take_beat(1);
      if (b.rid == 4'h4) begin
        check_beat("crossing", b, 4'h4, 32'h4000_3000, k4, 3);
        k4++;
      end else if (b.rid == 4'h5) begin
        check_beat("crossing", b, 4'h5, 32'h8000_3000, k5, 3);
        k5++;
      end else begin
        errors++;
        $display("Beat with unexpected ID %h reached M1 in crossing", b.rid);
      end
    end
    check_equal("crossing", "S1 beats at M1", 4, 32'(k4));
    check_equal("crossing", "S2 beats at M1", 4, 32'(k5));
    check_no_extra_beats("crossing");
  endtask

  task automatic test_error();
    axi_r_m_t b;
    issue_read(1, 4'hb, 32'h4000_f000, 4'd1);
    wait_beats(1, 2);
    for (int k = 0; k < 2; k++) begin
      b = take_beat(1);
      check_beat("error", b, 4'hb, 32'h4000_f000, k, 1);
      check_equal("error", "M1 slverr", 32'(resp_slverr), 32'(b.rresp));
    end
    issue_read(0, 4'hc, 32'h0001_f010, 4'd0);
    wait_beats(0, 1);
    b = take_beat(0);
    check_beat("error", b, 4'hc, 32'h0001_f010, 0, 0);
    check_equal("error", "M0 slverr", 32'(resp_slverr), 32'(b.rresp));
  endtask

  initial begin
    void'($urandom(90));
    rstn      = 1'b0;
    ar_m0     = '0;
    ar_m1     = '0;
    rready_m0 = 1'b1;
    rready_m1 = 1'b1;
    repeat (10) @(negedge clk);
    rstn = 1'b1;
    test_reset_state();
    test_single();
    test_contention();
    test_burst();
    test_backpressure();
    test_crossing();
    test_error();
    $display("Checks: %0d, value errors: %0d, handshake errors: %0d",
             checks, errors, hold_errors);
    if (errors == 0 && hold_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
common/axi_pkg.sv
common/xbar_map_pkg.sv
xbar/ar_router.sv
xbar/r_router.sv
xbar/read_xbar.sv
test/axi_slave_model.sv
test/read_xbar_props.sv
test/read_xbar_tb.sv

//--- Makefile
BIN  := obj_dir/Vread_xbar_tb
SRCS := $(filter %.sv,$(shell cat sim.f))

.PHONY: run clean

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "All checks passed" sim.log

$(BIN): sim.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module read_xbar_tb -Mdir obj_dir -f sim.f

clean:
	rm -rf obj_dir sim.log
